/* common/ccc_pkg.sv */
`default_nettype none

package ccc_pkg;

  localparam int         REGF_AW       = 8;      // register-file address width
  localparam logic [6:0] BCAST_ADDR    = 7'h7E;  // I3C broadcast address
  localparam logic [3:0] CRC_TOKEN     = 4'hC;
  localparam logic [4:0] CRC_INIT      = 5'h1F;  // crc-5 seed at every CMD word
  localparam logic [6:0] DEV_ADDR_BASE = 7'd8;   // dynamic address of device index 0

  // kind tag that rides along with every word through the pipeline
  typedef enum logic [2:0] {
    CMD,
    CCC,
    DATA,
    CRC,
    END_RESTART,
    END_EXIT
  } word_kind_e;

  typedef struct packed {
    logic        dbp;          // defining byte present
    logic        sre;
    logic [15:0] data_length;  // bytes, excluding the defining byte
  } desc_reg_t;

  typedef struct packed {
    logic [2:0]  dtt;     // 1-4 data only, 5-7 defining byte + (dtt-4) data
    logic [14:0] unused;
  } desc_imm_t;

  // same 18 bits, read by the imm attribute of the descriptor
  typedef union packed {
    desc_reg_t regular;
    desc_imm_t immed;
  } desc_body_u;

  typedef struct packed {
    logic       rnw;
    logic       imm;        // attribute bit, 1 = immediate
    logic [7:0] ccc;
    logic [4:0] dev_index;
    logic       toc;        // 1 = exit pattern at the end
    desc_body_u body;
  } cmd_desc_t;

  typedef struct packed {
    logic        direct;
    logic        has_def;
    logic [6:0]  target_addr;
    logic        rnw;
    logic        toc;
    logic        imm;
    logic [15:0] byte_count;
    logic [7:0]  ccc;         // code for the CCC word
  } ccc_plan_t;

  // on the line only preamble, payload and parity go out (20 bits)
  typedef struct packed {
    word_kind_e  kind;
    logic [1:0]  preamble;
    logic [15:0] payload;
    logic [1:0]  parity;
  } ddr_word_t;

  // codes sent as direct CCCs, everything else is broadcast
  function automatic logic is_direct_ccc(input logic [7:0] code);
    case (code)
      8'h80, 8'h81, 8'h89, 8'h8A, 8'h8B, 8'h8C, 8'h9A, 8'h90: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // PA1 over odd payload bits, PA0 over even bits, inverted
  function automatic logic [1:0] ddr_parity(input logic [15:0] p);
    logic pa1;
    logic pa0;
    pa1 = 1'b0;
    pa0 = 1'b0;
    for (int i = 0; i < 8; i++) begin
      pa1 ^= p[2*i+1];
      pa0 ^= p[2*i];
    end
    return {pa1, ~pa0};
  endfunction

  // crc-5, poly x^5+x^2+1, one byte msb first
  function automatic logic [4:0] crc5_byte(input logic [4:0] crc, input logic [7:0] data);
    logic [4:0] c;
    logic       fb;
    c = crc;
    for (int i = 7; i >= 0; i--) begin
      fb = c[4] ^ data[i];
      c  = {c[3:0], 1'b0};
      if (fb) c = c ^ 5'h05;  // taps x^2 and x^0
    end
    return c;
  endfunction

endpackage

`default_nettype wire

/* source/ccc_desc_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module ccc_desc_decoder (
  input  logic               i_sys_clk,
  input  logic               i_sys_rst,
  input  logic               i_cmd_valid,
  input  ccc_pkg::cmd_desc_t i_cmd,
  input  logic               i_frame_done,
  output logic               o_busy,
  output logic               o_plan_valid,
  output ccc_pkg::ccc_plan_t o_plan
);
  import ccc_pkg::*;

  cmd_desc_t  desc_q;   // descriptor held for the whole command
  logic       accept;
  logic [2:0] dtt;
  logic [15:0] imm_count;

  assign accept = i_cmd_valid && !o_busy;
  assign dtt    = desc_q.body.immed.dtt;

  // busy from acceptance until the fsm reports the last frame
  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      o_busy       <= 1'b0;
      o_plan_valid <= 1'b0;
    end else begin
      o_plan_valid <= accept;  // one pulse, plan is valid the cycle after
      if (accept) begin
        o_busy <= 1'b1;
      end else if (i_frame_done) begin
        o_busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_sys_clk) begin
    if (accept) desc_q <= i_cmd;
  end

  // immediate byte count, defining byte not included
  always_comb begin
    case (dtt)
      3'd1, 3'd2, 3'd3, 3'd4: imm_count = {13'd0, dtt};
      3'd5, 3'd6, 3'd7:       imm_count = {13'd0, dtt - 3'd4};
      default:                imm_count = 16'd0;  // dtt 0 carries nothing
    endcase
  end

  always_comb begin
    o_plan.direct      = is_direct_ccc(desc_q.ccc);
    o_plan.target_addr = DEV_ADDR_BASE + {2'b00, desc_q.dev_index};  // index + 8
    o_plan.rnw         = desc_q.rnw;
    o_plan.toc         = desc_q.toc;
    o_plan.imm         = desc_q.imm;
    o_plan.ccc         = desc_q.ccc;
    if (desc_q.imm) begin
      o_plan.has_def    = (dtt >= 3'd5);
      o_plan.byte_count = imm_count;
    end else begin
      o_plan.has_def    = desc_q.body.regular.dbp;
      o_plan.byte_count = desc_q.body.regular.data_length;
    end
  end

endmodule

`default_nettype wire

/* ccc_engine/ccc_frame_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module ccc_frame_fsm #(
  parameter logic [ccc_pkg::REGF_AW-1:0] REGF_BASE = 8'h10
) (
  input  logic                         i_sys_clk,
  input  logic                         i_sys_rst,
  input  logic                         i_plan_valid,
  input  ccc_pkg::ccc_plan_t           i_plan,
  input  logic [15:0]                  i_regf_rdata,
  input  logic                         i_req_ready,
  output logic                         o_regf_rd_en,
  output logic [ccc_pkg::REGF_AW-1:0]  o_regf_addr,
  output logic                         o_req_valid,
  output ccc_pkg::word_kind_e          o_req_kind,
  output logic [15:0]                  o_req_payload,
  output logic                         o_req_two_bytes,
  output logic                         o_frame_done
);
  import ccc_pkg::*;

  localparam logic [REGF_AW-1:0] DEF_OFS = 2;  // defining byte, upper half
  localparam logic [REGF_AW-1:0] IMM_OFS = 3;  // first immediate data location
  localparam logic [REGF_AW-1:0] REG_OFS = 4;  // first regular data location

  typedef enum logic [2:0] {S_IDLE, S_CMD, S_CCC, S_DATA, S_CRC, S_END} state_e;

  state_e             state_q, state_d;
  ccc_plan_t          plan_q;
  logic               hdr_q;        // direct CCC, still in the 7E header frame
  logic [REGF_AW-1:0] rd_ptr_q;     // next data location
  logic [15:0]        remain_q;     // data bytes not yet requested
  logic [15:0]        remain_left;
  logic               rd_pend_q;    // rdata arrives this cycle
  logic [15:0]        rd_hold_q;    // keeps rdata through a stall
  logic [15:0]        rd_data;
  logic               bcast_frame;
  logic               data_two;
  logic               take;
  logic               data_rd;
  logic               def_rd;

  assign take         = o_req_valid && i_req_ready;
  assign bcast_frame  = hdr_q || !plan_q.direct;   // CMD to 7E with RnW 0
  assign rd_data      = rd_pend_q ? i_regf_rdata : rd_hold_q;
  assign data_two     = (remain_q != 16'd1);       // last odd byte gets a pad
  assign remain_left  = remain_q - (data_two ? 16'd2 : 16'd1);
  assign o_req_valid  = (state_q != S_IDLE);
  assign o_regf_rd_en = data_rd || def_rd;
  assign o_regf_addr  = def_rd ? REGF_BASE + DEF_OFS : rd_ptr_q;

  // reads go out on the handshake of the word before the one that needs them
  always_comb begin
    state_d         = state_q;
    o_req_kind      = CMD;
    o_req_payload   = 16'd0;
    o_req_two_bytes = 1'b1;
    data_rd         = 1'b0;
    def_rd          = 1'b0;
    case (state_q)
      S_IDLE: if (i_plan_valid) state_d = S_CMD;
      S_CMD: begin
        o_req_kind    = CMD;
        o_req_payload = bcast_frame ? {1'b0, 7'd0, BCAST_ADDR, 1'b0}
                                    : {plan_q.rnw, 7'd0, plan_q.target_addr, 1'b0};
        if (take) begin
          if (bcast_frame) begin
            state_d = S_CCC;
            def_rd  = plan_q.has_def;
          end else if (remain_q != 16'd0) begin
            state_d = S_DATA;
            data_rd = 1'b1;
          end else begin
            state_d = S_CRC;   // target frame without data
          end
        end
      end
      S_CCC: begin
        o_req_kind    = CCC;
        o_req_payload = {plan_q.ccc, plan_q.has_def ? rd_data[15:8] : 8'h00};
        if (take) begin
          if (!hdr_q && remain_q != 16'd0) begin
            state_d = S_DATA;  // broadcast carries data in the same frame
            data_rd = 1'b1;
          end else begin
            state_d = S_CRC;
          end
        end
      end
      S_DATA: begin
        o_req_kind      = DATA;
        o_req_payload   = {rd_data[15:8], data_two ? rd_data[7:0] : 8'h00};
        o_req_two_bytes = data_two;
        if (take) begin
          if (remain_left != 16'd0) data_rd = 1'b1;
          else state_d = S_CRC;
        end
      end
      S_CRC: begin
        o_req_kind = CRC;  // builder fills in token and checksum
        if (take) state_d = S_END;
      end
      S_END: begin
        o_req_kind = (!hdr_q && plan_q.toc) ? END_EXIT : END_RESTART;
        if (take) state_d = hdr_q ? S_CMD : S_IDLE;
      end
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      state_q      <= S_IDLE;
      hdr_q        <= 1'b0;
      rd_ptr_q     <= '0;
      remain_q     <= 16'd0;
      rd_pend_q    <= 1'b0;
      o_frame_done <= 1'b0;
    end else begin
      state_q      <= state_d;
      rd_pend_q    <= o_regf_rd_en;
      o_frame_done <= take && (state_q == S_END) && !hdr_q;
      if (state_q == S_IDLE && i_plan_valid) begin
        hdr_q    <= i_plan.direct;
        remain_q <= i_plan.byte_count;
        rd_ptr_q <= REGF_BASE + (i_plan.imm ? IMM_OFS : REG_OFS);
      end
      if (data_rd) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (take && state_q == S_DATA) remain_q <= remain_left;
      if (take && state_q == S_END) hdr_q <= 1'b0;  // on to the target frame
    end
  end

  always_ff @(posedge i_sys_clk) begin
    if (state_q == S_IDLE && i_plan_valid) plan_q <= i_plan;
    if (rd_pend_q) rd_hold_q <= i_regf_rdata;
  end

endmodule

`default_nettype wire

/* ccc_engine/ddr_word_builder.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr_word_builder (
  input  logic                i_sys_clk,
  input  logic                i_sys_rst,
  input  logic                i_req_valid,
  input  ccc_pkg::word_kind_e i_req_kind,
  input  logic [15:0]         i_req_payload,
  input  logic                i_req_two_bytes,
  input  logic                i_out_ready,
  output logic                o_req_ready,
  output logic                o_out_valid,
  output ccc_pkg::ddr_word_t  o_out_word
);
  import ccc_pkg::*;

  logic [4:0] crc_q;      // running checksum of the current frame
  logic [4:0] crc_hi;
  logic [4:0] crc_d;
  ddr_word_t  word_d;
  logic       take;

  assign o_req_ready = !o_out_valid || i_out_ready;  // slot empty or leaving
  assign take        = i_req_valid && o_req_ready;

  // upper byte first, the pad byte of an odd data word is skipped
  assign crc_hi = crc5_byte(crc_q, i_req_payload[15:8]);

  always_comb begin
    case (i_req_kind)
      CMD:       crc_d = CRC_INIT;  // new frame
      CCC, DATA: crc_d = i_req_two_bytes ? crc5_byte(crc_hi, i_req_payload[7:0]) : crc_hi;
      default:   crc_d = crc_q;
    endcase
  end

  always_comb begin
    word_d.kind     = i_req_kind;
    word_d.payload  = i_req_payload;
    word_d.parity   = ddr_parity(i_req_payload);
    word_d.preamble = 2'b10;
    case (i_req_kind)
      CMD:       word_d.preamble = 2'b01;
      CCC, DATA: word_d.preamble = 2'b10;
      CRC: begin
        word_d.preamble = 2'b01;
        word_d.payload  = {CRC_TOKEN, crc_q, 7'd0};
        word_d.parity   = 2'b00;  // crc word has no parity
      end
      default: begin            // restart / exit
        word_d.preamble = 2'b00;
        word_d.payload  = 16'd0;
        word_d.parity   = 2'b00;
      end
    endcase
  end

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      o_out_valid <= 1'b0;
      crc_q       <= CRC_INIT;
    end else begin
      if (take) begin
        o_out_valid <= 1'b1;
        crc_q       <= crc_d;
      end else if (i_out_ready) begin
        o_out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_sys_clk) begin
    if (take) o_out_word <= word_d;
  end

endmodule

`default_nettype wire

/* source/word_credit_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module word_credit_tx #(
  parameter int MAX_CREDITS = 4
) (
  input  logic               i_sys_clk,
  input  logic               i_sys_rst,
  input  logic               i_in_valid,
  input  ccc_pkg::ddr_word_t i_in_word,
  input  logic               i_credit_return,
  output logic               o_in_ready,
  output logic               o_word_valid,
  output ccc_pkg::ddr_word_t o_word,
  output logic               o_done
);
  import ccc_pkg::*;

  localparam int CW = $clog2(MAX_CREDITS + 1);

  logic [CW-1:0] credit_cnt;
  logic          pend_q;       // o_word holds a word not yet sent
  logic          hdr_end_q;    // frame carried a direct CCC, its END is not the last
  logic          take;
  logic          is_end;

  assign o_word_valid = pend_q && (credit_cnt != '0);
  assign o_in_ready   = !pend_q || o_word_valid;
  assign take         = i_in_valid && o_in_ready;
  assign is_end       = (o_word.kind == END_RESTART) || (o_word.kind == END_EXIT);

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      pend_q     <= 1'b0;
      credit_cnt <= CW'(MAX_CREDITS);
      hdr_end_q  <= 1'b0;
      o_done     <= 1'b0;
    end else begin
      if (take) pend_q <= 1'b1;
      else if (o_word_valid) pend_q <= 1'b0;
      case ({o_word_valid, i_credit_return})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;  // spend
        2'b01:   credit_cnt <= credit_cnt + 1'b1;  // return
        default: credit_cnt <= credit_cnt;         // none, or both at once
      endcase
      // header frame has a direct code in its CCC word, target frame has none
      if (o_word_valid && o_word.kind == CMD) hdr_end_q <= 1'b0;
      if (o_word_valid && o_word.kind == CCC) hdr_end_q <= is_direct_ccc(o_word.payload[15:8]);
      o_done <= o_word_valid && is_end && !hdr_end_q;
    end
  end

  always_ff @(posedge i_sys_clk) begin
    if (take) o_word <= i_in_word;
  end

endmodule

`default_nettype wire

/* source/ccc_master_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ccc_master_top #(
  parameter int                          MAX_CREDITS = 4,
  parameter logic [ccc_pkg::REGF_AW-1:0] REGF_BASE   = 8'h10
) (
  input  logic                         i_sys_clk,
  input  logic                         i_sys_rst,
  input  logic                         i_cmd_valid,
  input  ccc_pkg::cmd_desc_t           i_cmd,
  output logic                         o_busy,
  output logic                         o_regf_rd_en,
  output logic [ccc_pkg::REGF_AW-1:0]  o_regf_addr,
  input  logic [15:0]                  i_regf_rdata,
  output logic                         o_word_valid,
  output ccc_pkg::ddr_word_t           o_word,
  input  logic                         i_credit_return,
  output logic                         o_done
);
  import ccc_pkg::*;

  ccc_plan_t   plan;
  logic        plan_valid;
  logic        frame_done;
  logic        req_valid;
  logic        req_ready;
  word_kind_e  req_kind;
  logic [15:0] req_payload;
  logic        req_two_bytes;
  logic        built_valid;
  logic        built_ready;
  ddr_word_t   built_word;

  ccc_desc_decoder u_decoder (
    .i_sys_clk    (i_sys_clk),
    .i_sys_rst    (i_sys_rst),
    .i_cmd_valid  (i_cmd_valid),
    .i_cmd        (i_cmd),
    .i_frame_done (frame_done),
    .o_busy       (o_busy),
    .o_plan_valid (plan_valid),
    .o_plan       (plan)
  );

  ccc_frame_fsm #(
    .REGF_BASE (REGF_BASE)
  ) u_frame_fsm (
    .i_sys_clk       (i_sys_clk),
    .i_sys_rst       (i_sys_rst),
    .i_plan_valid    (plan_valid),
    .i_plan          (plan),
    .i_regf_rdata    (i_regf_rdata),
    .i_req_ready     (req_ready),
    .o_regf_rd_en    (o_regf_rd_en),
    .o_regf_addr     (o_regf_addr),
    .o_req_valid     (req_valid),
    .o_req_kind      (req_kind),
    .o_req_payload   (req_payload),
    .o_req_two_bytes (req_two_bytes),
    .o_frame_done    (frame_done)
  );

  ddr_word_builder u_builder (
    .i_sys_clk       (i_sys_clk),
    .i_sys_rst       (i_sys_rst),
    .i_req_valid     (req_valid),
    .i_req_kind      (req_kind),
    .i_req_payload   (req_payload),
    .i_req_two_bytes (req_two_bytes),
    .i_out_ready     (built_ready),
    .o_req_ready     (req_ready),
    .o_out_valid     (built_valid),
    .o_out_word      (built_word)
  );

  word_credit_tx #(
    .MAX_CREDITS (MAX_CREDITS)
  ) u_credit_tx (
    .i_sys_clk       (i_sys_clk),
    .i_sys_rst       (i_sys_rst),
    .i_in_valid      (built_valid),
    .i_in_word       (built_word),
    .i_credit_return (i_credit_return),
    .o_in_ready      (built_ready),
    .o_word_valid    (o_word_valid),
    .o_word          (o_word),
    .o_done          (o_done)
  );

endmodule

`default_nettype wire

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 16
) (
  output logic o_sys_clk,
  output logic o_sys_rst   // active low
);

  initial begin
    o_sys_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_sys_clk = ~o_sys_clk;  // 50% duty
  end

  initial begin
    o_sys_rst <= 1'b0;
    repeat (RST_CYCLES) @(posedge o_sys_clk);
    o_sys_rst <= 1'b1;   // released on a rising edge
  end

endmodule

`default_nettype wire

/* tb/ccc_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module ccc_checker #(
  parameter int MAX_CREDITS = 4,
  parameter int CW          = 3
) (
  input  logic               i_sys_clk,
  input  logic               i_sys_rst,
  input  logic [CW-1:0]      i_credit_cnt,
  input  logic               i_word_valid,
  input  logic               i_credit_return,
  input  logic               i_pend,        // output register holds a word
  input  ccc_pkg::ddr_word_t i_word
);

  int model_credits;  // credits left, from words sent and returns seen

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      model_credits <= MAX_CREDITS;
    end else begin
      model_credits <= model_credits - int'(i_word_valid) + int'(i_credit_return);
    end
  end

  // a word only leaves while a credit is held
  assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    i_word_valid |-> (model_credits > 0))
    else $error("word sent with zero credit");

  // returns never push the count past its reset value
  assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    i_credit_cnt <= CW'(MAX_CREDITS))
    else $error("credit count above the maximum");

  // stalled word stays put until a credit comes back
  assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    (i_pend && !i_word_valid) |=> $stable(i_word))
    else $error("output word changed while stalled");

endmodule

bind word_credit_tx ccc_checker #(
  .MAX_CREDITS (MAX_CREDITS),
  .CW          (CW)
) u_checker (
  .i_sys_clk       (i_sys_clk),
  .i_sys_rst       (i_sys_rst),
  .i_credit_cnt    (credit_cnt),
  .i_word_valid    (o_word_valid),
  .i_credit_return (i_credit_return),
  .i_pend          (pend_q),
  .i_word          (o_word)
);

`default_nettype wire

/* tb/ccc_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ccc_tb;
  import ccc_pkg::*;

  localparam int                 MAX_CREDITS    = 4;
  localparam logic [REGF_AW-1:0] REGF_BASE      = 8'h10;
  localparam int                 RST_CYCLES     = 16;
  localparam int                 TIMEOUT_CYCLES = 6 * 16 * 8 + RST_CYCLES;  // tests x words x cycles

  logic        sys_clk;
  logic        sys_rst;
  logic        cmd_valid;
  cmd_desc_t   cmd;
  logic        busy;
  logic        regf_rd_en;
  logic [REGF_AW-1:0] regf_addr;
  logic [15:0] regf_rdata = 16'd0;
  logic        word_valid;
  ddr_word_t   word;
  logic        credit_ret = 1'b0;
  logic        done;

  logic [15:0] regf_mem [0:255];     // register-file contents
  logic [15:0] lfsr_q = 16'd4;       // seed
  logic [15:0] delay_bits;
  logic        hold_credits = 1'b0;  // back-pressure switch
  ddr_word_t   exp_q [$];            // words still expected on the line
  int          credit_q [$];         // cycle each spent credit comes back
  int          cycle_cnt = 0;
  int          words_seen = 0;
  int          done_cnt = 0;
  int          err_cnt = 0;
  int          check_cnt = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  tb_clk_gen #(.PERIOD_NS(40), .RST_CYCLES(RST_CYCLES)) u_clk_gen (
    .o_sys_clk (sys_clk),
    .o_sys_rst (sys_rst)
  );

  ccc_master_top #(.MAX_CREDITS(MAX_CREDITS), .REGF_BASE(REGF_BASE)) dut (
    .i_sys_clk       (sys_clk),
    .i_sys_rst       (sys_rst),
    .i_cmd_valid     (cmd_valid),
    .i_cmd           (cmd),
    .o_busy          (busy),
    .o_regf_rd_en    (regf_rd_en),
    .o_regf_addr     (regf_addr),
    .i_regf_rdata    (regf_rdata),
    .o_word_valid    (word_valid),
    .o_word          (word),
    .i_credit_return (credit_ret),
    .o_done          (done)
  );

  // galois lfsr, taps 16,14,13,11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[14:0], lfsr_q[0]};  // one step per bit
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic fill_regf();
    logic [15:0] v;
    for (int a = 0; a < 256; a++) begin
      rand_bits(16, v);
      regf_mem[a] = v ^ {a[7:0], ~a[7:0]};  // address folded in
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  function automatic logic code_is_direct(input logic [7:0] code);
    return code inside {8'h80, 8'h81, 8'h89, 8'h8A, 8'h8B, 8'h8C, 8'h9A, 8'h90};
  endfunction

  function automatic logic [1:0] parity_of(input logic [15:0] p);
    return {^(p & 16'hAAAA), ~(^(p & 16'h5555))};  // odd bits, even bits inverted
  endfunction

  // x^5+x^2+1, msb first
  function automatic logic [4:0] crc5_step(input logic [4:0] crc, input logic [7:0] b);
    logic [4:0] c;
    logic       fb;
    c = crc;
    for (int i = 7; i >= 0; i--) begin
      fb   = c[4] ^ b[i];
      c    = {c[3:0], fb};  // x^0 tap
      c[2] = c[2] ^ fb;     // x^2 tap
    end
    return c;
  endfunction

  function automatic logic [7:0] data_byte(input int base, input int k);
    logic [15:0] w;
    w = regf_mem[base + k / 2];
    return (k % 2 == 0) ? w[15:8] : w[7:0];  // upper byte first
  endfunction

  function automatic void push_word(input word_kind_e kind, input logic [15:0] payload);
    ddr_word_t w;
    w.kind    = kind;
    w.payload = payload;
    w.parity  = 2'b00;
    case (kind)
      CMD: begin
        w.preamble = 2'b01;
        w.parity   = parity_of(payload);
      end
      CCC, DATA: begin
        w.preamble = 2'b10;
        w.parity   = parity_of(payload);
      end
      CRC:     w.preamble = 2'b01;
      default: begin
        w.preamble = 2'b00;  // restart or exit
        w.payload  = 16'd0;
      end
    endcase
    exp_q.push_back(w);
  endfunction

  // full word list for one descriptor
  function automatic void ref_words(input cmd_desc_t d);
    logic       direct;
    logic       has_def;
    int         n_bytes;
    int         base;
    logic [7:0] def_byte;
    logic [7:0] b0;
    logic [7:0] b1;
    logic [4:0] crc;
    logic [6:0] target;
    direct = code_is_direct(d.ccc);
    target = DEV_ADDR_BASE + {2'b00, d.dev_index};
    if (d.imm) begin
      has_def = (d.body.immed.dtt >= 3'd5);
      n_bytes = has_def ? int'(d.body.immed.dtt) - 4 : int'(d.body.immed.dtt);
      base    = REGF_BASE + 3;
    end else begin
      has_def = d.body.regular.dbp;
      n_bytes = int'(d.body.regular.data_length);
      base    = REGF_BASE + 4;
    end
    def_byte = has_def ? regf_mem[REGF_BASE + 2][15:8] : 8'h00;
    crc      = CRC_INIT;
    push_word(CMD, {1'b0, 7'd0, BCAST_ADDR, 1'b0});  // every CCC opens on 7E
    push_word(CCC, {d.ccc, def_byte});
    crc = crc5_step(crc5_step(crc, d.ccc), def_byte);
    if (direct) begin
      push_word(CRC, {CRC_TOKEN, crc, 7'd0});
      push_word(END_RESTART, 16'd0);
      crc = CRC_INIT;                                 // target frame
      push_word(CMD, {d.rnw, 7'd0, target, 1'b0});
    end
    for (int k = 0; k < n_bytes; k += 2) begin
      b0  = data_byte(base, k);
      b1  = (k + 1 < n_bytes) ? data_byte(base, k + 1) : 8'h00;
      crc = crc5_step(crc, b0);
      if (k + 1 < n_bytes) crc = crc5_step(crc, b1);  // pad stays out
      push_word(DATA, {b0, b1});
    end
    push_word(CRC, {CRC_TOKEN, crc, 7'd0});
    if (d.toc) push_word(END_EXIT, 16'd0);
    else push_word(END_RESTART, 16'd0);
  endfunction

  function automatic cmd_desc_t regular_desc(input logic rnw, input logic [7:0] ccc,
                                             input logic [4:0] dev, input logic toc,
                                             input logic dbp, input logic [15:0] len);
    cmd_desc_t d;
    d                          = '0;
    d.rnw                      = rnw;
    d.ccc                      = ccc;
    d.dev_index                = dev;
    d.toc                      = toc;
    d.body.regular.dbp         = dbp;
    d.body.regular.data_length = len;
    return d;
  endfunction

  function automatic cmd_desc_t immediate_desc(input logic rnw, input logic [7:0] ccc,
                                               input logic [4:0] dev, input logic toc,
                                               input logic [2:0] dtt);
    cmd_desc_t d;
    d                  = '0;
    d.rnw              = rnw;
    d.imm              = 1'b1;
    d.ccc              = ccc;
    d.dev_index        = dev;
    d.toc              = toc;
    d.body.immed.dtt   = dtt;
    return d;
  endfunction

  task automatic report_test(input string name, input int err0);
    tests_run++;
    if (err_cnt != err0) begin
      tests_failed++;
      $display("test %0d %s: FAILED, %0d errors", tests_run, name, err_cnt - err0);
    end else begin
      $display("test %0d %s: ok", tests_run, name);
    end
  endtask

  task automatic check_reset_state();
    int err0;
    err0 = err_cnt;
    check_value("o_busy", busy, 0);
    check_value("o_done", done, 0);
    check_value("o_word_valid", word_valid, 0);
    check_value("o_regf_rd_en", regf_rd_en, 0);
    report_test("outputs idle after reset", err0);
  endtask

  task automatic run_cmd(input string name, input cmd_desc_t d, input logic stall);
    int err0;
    int done0;
    int words0;
    int held;
    err0   = err_cnt;
    done0  = done_cnt;
    words0 = words_seen;
    ref_words(d);
    while (busy) @(posedge sys_clk);
    @(posedge sys_clk);
    hold_credits <= stall;
    cmd          <= d;
    cmd_valid    <= 1'b1;
    @(posedge sys_clk);
    cmd_valid <= 1'b0;
    if (stall) begin
      while (words_seen < words0 + MAX_CREDITS) @(posedge sys_clk);
      held = words_seen;
      repeat (40) @(posedge sys_clk);  // no credits come back here
      check_value("words sent without credit", words_seen, held);
      hold_credits <= 1'b0;
    end
    while (done_cnt == done0) @(posedge sys_clk);
    while (credit_q.size() != 0) @(posedge sys_clk);
    repeat (4) @(posedge sys_clk);     // last credit pulse lands
    if (exp_q.size() != 0) begin
      err_cnt++;
      $display("%0d expected words never left the DUT", exp_q.size());
      exp_q.delete();
    end
    check_value("o_done pulses", done_cnt - done0, 1);
    report_test(name, err0);
  endtask

  // register file, one cycle read latency
  always @(posedge sys_clk) begin
    if (regf_rd_en) regf_rdata <= regf_mem[regf_addr];
  end

  // one credit back per word, 0-3 cycles later
  always @(posedge sys_clk) begin
    credit_ret <= 1'b0;
    if (word_valid) begin
      rand_bits(2, delay_bits);
      credit_q.push_back(cycle_cnt + int'(delay_bits[1:0]));
    end
    if (!hold_credits && credit_q.size() != 0 && credit_q[0] <= cycle_cnt) begin
      void'(credit_q.pop_front());
      credit_ret <= 1'b1;
    end
  end

  // compare every word that leaves
  always @(posedge sys_clk) begin
    if (word_valid) begin
      words_seen <= words_seen + 1;
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("word 0x%0h left the DUT when none was expected", word);
      end else begin
        check_value("o_word", 32'(word), 32'(exp_q.pop_front()));
      end
    end
  end

  always @(posedge sys_clk) begin
    if (done) done_cnt <= done_cnt + 1;
  end

  always @(posedge sys_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    cmd_valid <= 1'b0;
    cmd       <= '0;
    fill_regf();
    wait (sys_rst === 1'b1);
    @(posedge sys_clk);
    check_reset_state();
    run_cmd("broadcast, 3 data bytes, exit", regular_desc(1'b0, 8'h01, 5'd0, 1'b1, 1'b0, 16'd3),
            1'b0);
    run_cmd("broadcast with defining byte", regular_desc(1'b0, 8'h08, 5'd0, 1'b0, 1'b1, 16'd2),
            1'b0);
    run_cmd("immediate direct write, dtt 6", immediate_desc(1'b0, 8'h9A, 5'd3, 1'b1, 3'd6),
            1'b0);
    run_cmd("direct read, exit", regular_desc(1'b1, 8'h8B, 5'd5, 1'b1, 1'b0, 16'd2), 1'b0);
    run_cmd("broadcast under back-pressure", regular_desc(1'b0, 8'h00, 5'd0, 1'b1, 1'b0, 16'd8),
            1'b1);
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
common/ccc_pkg.sv
source/ccc_desc_decoder.sv
ccc_engine/ccc_frame_fsm.sv
ccc_engine/ddr_word_builder.sv
source/word_credit_tx.sv
source/ccc_master_top.sv
tb/tb_clk_gen.sv
tb/ccc_checker.sv
tb/ccc_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the CCC engine testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module ccc_tb -f src.f -o ccc_sim

# a failing run is judged by the search below
sim_out="$(./obj_dir/ccc_sim)" || true
echo "$sim_out"

if grep -qx "RESULT: PASS" <<< "$sim_out"; then
  exit 0
fi
exit 1
